// File: Makefile
# Verilator build and run of the block device subsystem testbench
# Override any variable on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= blk_dev_subsys_tb
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR=$(VERILATOR) TOP=$(TOP) LOG=$(LOG)"

test:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: blk_defines.svh
// ============================================================
// Shared sizes and slot numbers of the host block interface
// Slot 0 is the host boot device and carries no client here
// Sector size is fixed, multi-sector transfers do not occur
// ============================================================

`ifndef BLK_DEFINES_SVH
`define BLK_DEFINES_SVH

// Number of virtual disk slots served by the host
`define BLK_VDNUM 3

// Slot carrying the floppy sector reader
`define BLK_SLOT_FDD 1

// Slot carrying the NVRAM sector store
`define BLK_SLOT_NV 2

// Bytes in one sector, the only transfer size used
`define BLK_SECTOR_BYTES 512

`endif

// File: blk_dev_mux.sv
// ============================================================
// Routes the floppy and NVRAM clients onto their host slots
// Mount info is latched one cycle after the img_mounted pulse
// A disabled slot sees no ack, no buffer writes and size zero
// Requests pass through ungated and slot 0 is driven idle
// Mounted flags clear on rst and are set by any mount pulse
// ============================================================

`timescale 1ns/10ps
`default_nettype none

`include "blk_defines.svh"

module blk_dev_mux (
    input  wire                         clk,
    input  wire                         rst,
    input  wire blk_pkg::slot_vec_t     slot_en,
    input  wire blk_pkg::slot_vec_t     sd_ack,
    input  wire blk_pkg::buff_addr_t    sd_buff_addr,
    input  wire blk_pkg::byte_t         sd_buff_dout,
    input  wire                         sd_buff_wr,
    input  wire blk_pkg::slot_vec_t     img_mounted,
    input  wire blk_pkg::img_size_t     img_size,
    input  wire                         img_readonly,
    input  wire blk_pkg::lba_t          fdd_lba,
    input  wire                         fdd_rd,
    input  wire blk_pkg::lba_t          nv_lba,
    input  wire                         nv_wr,
    input  wire blk_pkg::byte_t         nv_buff_din,
    output blk_pkg::lba_t               sd_lba [`BLK_VDNUM],
    output blk_pkg::blk_cnt_t           sd_blk_cnt [`BLK_VDNUM],
    output blk_pkg::slot_vec_t          sd_rd,
    output blk_pkg::slot_vec_t          sd_wr,
    output blk_pkg::byte_t              sd_buff_din [`BLK_VDNUM],
    output logic                        fdd_ack,
    output logic                        fdd_buff_wr,
    output logic                        fdd_mounted,
    output blk_pkg::img_size_t          fdd_img_size,
    output logic                        nv_ack,
    output blk_pkg::buff_addr_t         nv_buff_addr,
    output logic                        nv_mounted,
    output logic                        nv_readonly,
    output blk_pkg::buff_addr_t         buff_addr,
    output blk_pkg::byte_t              buff_dout
);

    // Latched image information of the two client slots
    blk_pkg::img_size_t fdd_size_q;
    logic               nv_ro_q;

    // The floppy only needs the size, the NVRAM only the write protection
    always_ff @(posedge clk) begin
        if (img_mounted[`BLK_SLOT_FDD]) begin
            fdd_size_q <= img_size;
        end
        if (img_mounted[`BLK_SLOT_NV]) begin
            nv_ro_q <= img_readonly;
        end
    end

    // Mounted flags stay set until the next reset
    always_ff @(posedge clk) begin
        if (rst) begin
            fdd_mounted <= 1'b0;
            nv_mounted  <= 1'b0;
        end else begin
            if (img_mounted[`BLK_SLOT_FDD]) begin
                fdd_mounted <= 1'b1;
            end
            if (img_mounted[`BLK_SLOT_NV]) begin
                nv_mounted <= 1'b1;
            end
        end
    end

    // Every slot starts idle, then the client slots take their requests
    always_comb begin
        for (int s = 0; s < `BLK_VDNUM; s++) begin
            sd_lba[s]      = '0;
            sd_blk_cnt[s]  = '0;
            sd_buff_din[s] = '0;
        end
        sd_rd = '0;
        sd_wr = '0;
        sd_lba[`BLK_SLOT_FDD]     = fdd_lba;
        sd_rd[`BLK_SLOT_FDD]      = fdd_rd;
        sd_lba[`BLK_SLOT_NV]      = nv_lba;
        sd_wr[`BLK_SLOT_NV]       = nv_wr;
        sd_buff_din[`BLK_SLOT_NV] = nv_buff_din;
    end

    // Floppy side returns, gated by its enable bit
    assign fdd_ack      = slot_en[`BLK_SLOT_FDD] & sd_ack[`BLK_SLOT_FDD];
    assign fdd_buff_wr  = slot_en[`BLK_SLOT_FDD] & sd_buff_wr;
    assign fdd_img_size = slot_en[`BLK_SLOT_FDD] ? fdd_size_q : '0;

    // NVRAM side returns, the store only reads the buffer address
    assign nv_ack       = slot_en[`BLK_SLOT_NV] & sd_ack[`BLK_SLOT_NV];
    assign nv_buff_addr = slot_en[`BLK_SLOT_NV] ? sd_buff_addr : '0;
    assign nv_readonly  = nv_ro_q;

    // Buffer address and data are common to all slots
    assign buff_addr = sd_buff_addr;
    assign buff_dout = sd_buff_dout;

endmodule

`default_nettype wire

// File: blk_dev_subsys.sv
// ============================================================
// Floppy reader and NVRAM store on the host block interface
// Floppy uses slot 1, NVRAM slot 2, slot 0 is left idle
// slot_en gates the host responses of each client slot
// No registers are added at this level
// ============================================================

`timescale 1ns/10ps
`default_nettype none

`include "blk_defines.svh"

module blk_dev_subsys (
    input  wire                         clk,
    input  wire                         rst,
    input  wire blk_pkg::slot_vec_t     slot_en,
    input  wire blk_pkg::slot_vec_t     sd_ack,
    input  wire blk_pkg::buff_addr_t    sd_buff_addr,
    input  wire blk_pkg::byte_t         sd_buff_dout,
    input  wire                         sd_buff_wr,
    input  wire blk_pkg::slot_vec_t     img_mounted,
    input  wire blk_pkg::img_size_t     img_size,
    input  wire                         img_readonly,
    output blk_pkg::lba_t               sd_lba [`BLK_VDNUM],
    output blk_pkg::blk_cnt_t           sd_blk_cnt [`BLK_VDNUM],
    output blk_pkg::slot_vec_t          sd_rd,
    output blk_pkg::slot_vec_t          sd_wr,
    output blk_pkg::byte_t              sd_buff_din [`BLK_VDNUM],
    input  wire                         fdd_start,
    input  wire blk_pkg::lba_t          fdd_lba,
    output logic                        fdd_done,
    output logic                        fdd_err,
    output blk_pkg::csum_t              fdd_csum,
    input  wire                         core_we,
    input  wire blk_pkg::sector_idx_t   core_addr,
    input  wire blk_pkg::byte_t         core_data,
    output blk_pkg::byte_t              core_q,
    input  wire                         nv_save,
    input  wire blk_pkg::lba_t          nv_lba,
    output logic                        nv_saved,
    output logic                        nv_err
);

    // Floppy client to mux
    blk_pkg::lba_t       fdd_req_lba;
    logic                fdd_rd;
    logic                fdd_ack;
    logic                fdd_buff_wr;
    logic                fdd_mounted;
    blk_pkg::img_size_t  fdd_img_size;

    // NVRAM client to mux
    blk_pkg::lba_t       nv_req_lba;
    logic                nv_wr;
    blk_pkg::byte_t      nv_buff_din;
    logic                nv_ack;
    blk_pkg::buff_addr_t nv_buff_addr;
    logic                nv_mounted;
    logic                nv_readonly;

    // Shared buffer port seen by the floppy
    blk_pkg::buff_addr_t buff_addr;
    blk_pkg::byte_t      buff_dout;

    blk_dev_mux mux0 (
        .clk          (clk),
        .rst          (rst),
        .slot_en      (slot_en),
        .sd_ack       (sd_ack),
        .sd_buff_addr (sd_buff_addr),
        .sd_buff_dout (sd_buff_dout),
        .sd_buff_wr   (sd_buff_wr),
        .img_mounted  (img_mounted),
        .img_size     (img_size),
        .img_readonly (img_readonly),
        .fdd_lba      (fdd_req_lba),
        .fdd_rd       (fdd_rd),
        .nv_lba       (nv_req_lba),
        .nv_wr        (nv_wr),
        .nv_buff_din  (nv_buff_din),
        .sd_lba       (sd_lba),
        .sd_blk_cnt   (sd_blk_cnt),
        .sd_rd        (sd_rd),
        .sd_wr        (sd_wr),
        .sd_buff_din  (sd_buff_din),
        .fdd_ack      (fdd_ack),
        .fdd_buff_wr  (fdd_buff_wr),
        .fdd_mounted  (fdd_mounted),
        .fdd_img_size (fdd_img_size),
        .nv_ack       (nv_ack),
        .nv_buff_addr (nv_buff_addr),
        .nv_mounted   (nv_mounted),
        .nv_readonly  (nv_readonly),
        .buff_addr    (buff_addr),
        .buff_dout    (buff_dout)
    );

    fdd_sector_reader fdd0 (
        .clk       (clk),
        .rst       (rst),
        .start     (fdd_start),
        .start_lba (fdd_lba),
        .ack       (fdd_ack),
        .buff_wr   (fdd_buff_wr),
        .buff_addr (buff_addr),
        .buff_dout (buff_dout),
        .mounted   (fdd_mounted),
        .img_size  (fdd_img_size),
        .lba       (fdd_req_lba),
        .rd        (fdd_rd),
        .done      (fdd_done),
        .err       (fdd_err),
        .csum      (fdd_csum)
    );

    nvram_sector_store nv0 (
        .clk       (clk),
        .rst       (rst),
        .core_we   (core_we),
        .core_addr (core_addr),
        .core_data (core_data),
        .save      (nv_save),
        .save_lba  (nv_lba),
        .ack       (nv_ack),
        .buff_addr (nv_buff_addr),
        .mounted   (nv_mounted),
        .readonly  (nv_readonly),
        .core_q    (core_q),
        .lba       (nv_req_lba),
        .wr        (nv_wr),
        .buff_din  (nv_buff_din),
        .saved     (nv_saved),
        .err       (nv_err)
    );

endmodule

`default_nettype wire

// File: blk_dev_subsys_chk.sv
// ============================================================
// Host slot protocol checks, bound into blk_dev_subsys
// Only the floppy and NVRAM slots ever carry requests
// Checks are off while rst is high
// ============================================================

`timescale 1ns/10ps
`default_nettype none

`include "blk_defines.svh"

module blk_dev_subsys_chk (
    input wire                     clk,
    input wire                     rst,
    input wire blk_pkg::slot_vec_t sd_rd,
    input wire blk_pkg::slot_vec_t sd_wr,
    input wire blk_pkg::slot_vec_t sd_ack
);

    // Slot 0 is the host boot device and must stay quiet
    a_slot0_idle: assert property (@(posedge clk) disable iff (rst)
        !sd_rd[0] && !sd_wr[0])
        else $error("request raised on slot 0");

    for (genvar s = 1; s < `BLK_VDNUM; s++) begin : g_slot
        // A read request may only drop once the host has answered
        a_rd_hold: assert property (@(posedge clk) disable iff (rst)
            (sd_rd[s] && !sd_ack[s]) |=> sd_rd[s])
            else $error("rd dropped before ack on slot %0d", s);

        // Same rule for write requests
        a_wr_hold: assert property (@(posedge clk) disable iff (rst)
            (sd_wr[s] && !sd_ack[s]) |=> sd_wr[s])
            else $error("wr dropped before ack on slot %0d", s);

        // A slot never asks for both directions at once
        a_one_dir: assert property (@(posedge clk) disable iff (rst)
            !(sd_rd[s] && sd_wr[s]))
            else $error("rd and wr both high on slot %0d", s);
    end

endmodule

bind blk_dev_subsys blk_dev_subsys_chk chk0 (
    .clk    (clk),
    .rst    (rst),
    .sd_rd  (sd_rd),
    .sd_wr  (sd_wr),
    .sd_ack (sd_ack)
);

`default_nettype wire

// File: blk_dev_subsys_tb.sv
// ============================================================
// Testbench of the floppy reader and NVRAM store subsystem
// Inputs change on the falling edge, outputs are sampled there
// The host model serves one slot at a time with random delay
// Floppy image is 2880 sectors, the first error ends the run
// ============================================================

`timescale 1ns/10ps
`default_nettype none

`include "blk_defines.svh"

module blk_dev_subsys_tb;

    localparam int SECTOR      = `BLK_SECTOR_BYTES;
    localparam int FDD_SECTORS = 2880;
    localparam int CLK_NS      = 20;
    // One transfer is about 520 cycles, budget 600 and double it
    localparam int WATCHDOG_NS = 2 * 20 * 600 * CLK_NS;

    logic                clk;
    logic                rst;
    blk_pkg::slot_vec_t  slot_en;
    blk_pkg::slot_vec_t  sd_ack;
    blk_pkg::buff_addr_t sd_buff_addr;
    blk_pkg::byte_t      sd_buff_dout;
    logic                sd_buff_wr;
    blk_pkg::slot_vec_t  img_mounted;
    blk_pkg::img_size_t  img_size;
    logic                img_readonly;
    blk_pkg::lba_t       sd_lba [`BLK_VDNUM];
    blk_pkg::blk_cnt_t   sd_blk_cnt [`BLK_VDNUM];
    blk_pkg::slot_vec_t  sd_rd;
    blk_pkg::slot_vec_t  sd_wr;
    blk_pkg::byte_t      sd_buff_din [`BLK_VDNUM];
    logic                fdd_start;
    blk_pkg::lba_t       fdd_lba;
    logic                fdd_done;
    logic                fdd_err;
    blk_pkg::csum_t      fdd_csum;
    logic                core_we;
    blk_pkg::sector_idx_t core_addr;
    blk_pkg::byte_t      core_data;
    blk_pkg::byte_t      core_q;
    logic                nv_save;
    blk_pkg::lba_t       nv_lba;
    logic                nv_saved;
    logic                nv_err;

    // Expected checksums of reads in flight, in issue order
    blk_pkg::csum_t exp_csum_q [$];
    int             done_cnt;
    logic           verdict_given;
    // Model of the NVRAM contents and bytes the host received
    blk_pkg::byte_t nv_model [SECTOR];
    blk_pkg::byte_t host_rx [SECTOR];

    blk_dev_subsys dut0 (.*);

    always #(CLK_NS / 2) clk = ~clk;

    // Host data rule: byte n of sector lba is the low byte of lba + n
    function automatic blk_pkg::csum_t sector_csum(input blk_pkg::lba_t lba);
        blk_pkg::csum_t sum;
        sum = '0;
        for (int n = 0; n < SECTOR; n++) begin
            sum = sum + blk_pkg::csum_t'(blk_pkg::byte_t'(lba + blk_pkg::lba_t'(n)));
        end
        return sum;
    endfunction

    task automatic fail_now(input string msg);
        verdict_given = 1'b1;
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_csum(input string what, input blk_pkg::csum_t got,
                              input blk_pkg::csum_t exp);
        if (got !== exp) begin
            fail_now($sformatf("FAIL %0t ns: %s got %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_byte(input string what, input blk_pkg::byte_t got,
                              input blk_pkg::byte_t exp);
        if (got !== exp) begin
            fail_now($sformatf("FAIL %0t ns: %s got %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("FAIL %0t ns: %s got %b, expected %b", $time, what, got, exp));
        end
    endtask

    // Every fdd_done is matched against the oldest outstanding read
    always @(negedge clk) begin
        if (!rst && fdd_done) begin
            if (exp_csum_q.size() == 0) begin
                fail_now("Floppy reported done with no read outstanding");
            end else begin
                check_csum("fdd_csum", fdd_csum, exp_csum_q.pop_front());
                done_cnt++;
            end
        end
    end

    // Watchdog for a DUT or host model that never finishes
    initial begin
        #(WATCHDOG_NS);
        fail_now($sformatf("Timeout after %0d ns, a transfer never finished", WATCHDOG_NS));
    end

    // Every task starts and ends just after a falling edge
    task automatic apply_reset();
        rst = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic mount_slot(input int slot, input blk_pkg::img_size_t size, input logic ro);
        img_mounted[slot] = 1'b1;
        img_size          = size;
        img_readonly      = ro;
        @(negedge clk);
        img_mounted = '0;
    endtask

    // Host waits for a request, then answers after a random delay
    task automatic wait_request(input int slot);
        while (!(sd_rd[slot] || sd_wr[slot])) begin
            @(negedge clk);
        end
        // A single-sector request carries a block count of zero
        check_flag("block count is one sector", sd_blk_cnt[slot] == '0, 1'b1);
        repeat ($urandom % 8) @(negedge clk);
    endtask

    task automatic serve_read(input int slot);
        blk_pkg::lba_t lba;
        wait_request(slot);
        lba          = sd_lba[slot];
        sd_ack[slot] = 1'b1;
        for (int n = 0; n < SECTOR; n++) begin
            sd_buff_addr = blk_pkg::buff_addr_t'(n);
            sd_buff_dout = blk_pkg::byte_t'(lba + blk_pkg::lba_t'(n));
            sd_buff_wr   = 1'b1;
            @(negedge clk);
        end
        // A stray byte past the sector must not enter the checksum
        sd_buff_addr = blk_pkg::buff_addr_t'(SECTOR);
        sd_buff_dout = blk_pkg::byte_t'($urandom);
        @(negedge clk);
        sd_buff_wr   = 1'b0;
        sd_buff_addr = '0;
        sd_ack[slot] = 1'b0;
    endtask

    // Store data arrives one cycle after each address
    task automatic serve_write(input int slot);
        wait_request(slot);
        sd_ack[slot] = 1'b1;
        for (int n = 0; n < SECTOR; n++) begin
            sd_buff_addr = blk_pkg::buff_addr_t'(n);
            @(negedge clk);
            host_rx[n] = sd_buff_din[slot];
        end
        sd_buff_addr = '0;
        sd_ack[slot] = 1'b0;
    endtask

    task automatic start_read(input blk_pkg::lba_t lba);
        fdd_start = 1'b1;
        fdd_lba   = lba;
        @(negedge clk);
        fdd_start = 1'b0;
    endtask

    task automatic read_sector(input blk_pkg::lba_t lba);
        int seen;
        seen = done_cnt;
        exp_csum_q.push_back(sector_csum(lba));
        start_read(lba);
        serve_read(`BLK_SLOT_FDD);
        while (done_cnt == seen) begin
            @(negedge clk);
        end
    endtask

    // A rejected read pulses err at once and never requests
    task automatic reject_read(input blk_pkg::lba_t lba);
        start_read(lba);
        check_flag("fdd_err", fdd_err, 1'b1);
        repeat (8) begin
            @(negedge clk);
            check_flag("floppy rd", sd_rd[`BLK_SLOT_FDD], 1'b0);
        end
    endtask

    task automatic reject_save();
        nv_save = 1'b1;
        nv_lba  = 32'd7;
        @(negedge clk);
        nv_save = 1'b0;
        check_flag("nv_err", nv_err, 1'b1);
        repeat (8) begin
            @(negedge clk);
            check_flag("nvram wr", sd_wr[`BLK_SLOT_NV], 1'b0);
        end
    endtask

    initial begin
        blk_pkg::lba_t lba;
        int            seen;
        void'($urandom(32'he243_6c11));
        clk           = 1'b0;
        rst           = 1'b1;
        slot_en       = 3'b110;
        sd_ack        = '0;
        sd_buff_addr  = '0;
        sd_buff_dout  = '0;
        sd_buff_wr    = 1'b0;
        img_mounted   = '0;
        img_size      = '0;
        img_readonly  = 1'b0;
        fdd_start     = 1'b0;
        fdd_lba       = '0;
        core_we       = 1'b0;
        core_addr     = '0;
        core_data     = '0;
        nv_save       = 1'b0;
        nv_lba        = '0;
        done_cnt      = 0;
        verdict_given = 1'b0;
        @(negedge clk);
        apply_reset();

        // Floppy rejection while unmounted, then past the image end
        reject_read(32'd5);
        mount_slot(`BLK_SLOT_FDD, 64'(FDD_SECTORS * SECTOR), 1'b0);
        reject_read(blk_pkg::lba_t'(FDD_SECTORS));
        reject_read(32'hffff_ffff);

        // Floppy reads at random sectors and the last one
        repeat (8) begin
            read_sector(blk_pkg::lba_t'($urandom % FDD_SECTORS));
        end
        read_sector(blk_pkg::lba_t'(FDD_SECTORS - 1));

        // Fill the NVRAM from the core side and read it back
        for (int i = 0; i < SECTOR; i++) begin
            core_we     = 1'b1;
            core_addr   = blk_pkg::sector_idx_t'(i);
            core_data   = blk_pkg::byte_t'($urandom);
            nv_model[i] = core_data;
            @(negedge clk);
        end
        core_we = 1'b0;
        for (int i = 0; i < SECTOR; i++) begin
            core_addr = blk_pkg::sector_idx_t'(i);
            @(negedge clk);
            check_byte("core_q", core_q, nv_model[i]);
        end

        // Write-back to a writable image, saved follows ack by one cycle
        mount_slot(`BLK_SLOT_NV, 64'(SECTOR * 16), 1'b0);
        nv_save = 1'b1;
        nv_lba  = 32'd11;
        @(negedge clk);
        nv_save = 1'b0;
        check_flag("nvram lba on slot 2", sd_lba[`BLK_SLOT_NV] == 32'd11, 1'b1);
        serve_write(`BLK_SLOT_NV);
        @(negedge clk);
        check_flag("nv_saved", nv_saved, 1'b1);
        for (int i = 0; i < SECTOR; i++) begin
            check_byte($sformatf("host byte %0d", i), host_rx[i], nv_model[i]);
        end

        // Read-only image refuses the save
        mount_slot(`BLK_SLOT_NV, 64'(SECTOR * 16), 1'b1);
        reject_save();

        // Acks on a disabled slot never reach the reader
        lba  = blk_pkg::lba_t'($urandom % FDD_SECTORS);
        seen = done_cnt;
        exp_csum_q.push_back(sector_csum(lba));
        start_read(lba);
        slot_en[`BLK_SLOT_FDD] = 1'b0;
        serve_read(`BLK_SLOT_FDD);
        repeat (8) @(negedge clk);
        check_flag("floppy done while disabled", done_cnt != seen, 1'b0);
        check_flag("floppy rd held while disabled", sd_rd[`BLK_SLOT_FDD], 1'b1);
        // The held request completes once the slot is enabled again
        slot_en[`BLK_SLOT_FDD] = 1'b1;
        serve_read(`BLK_SLOT_FDD);
        while (done_cnt == seen) begin
            @(negedge clk);
        end
        read_sector(blk_pkg::lba_t'($urandom % FDD_SECTORS));

        // Reset clears both mounted flags until the next mount
        apply_reset();
        check_flag("floppy mounted after reset", dut0.mux0.fdd_mounted, 1'b0);
        check_flag("nvram mounted after reset", dut0.mux0.nv_mounted, 1'b0);
        reject_read(32'd3);
        reject_save();
        mount_slot(`BLK_SLOT_FDD, 64'(FDD_SECTORS * SECTOR), 1'b0);
        read_sector(32'd3);

        repeat (4) @(negedge clk);
        verdict_given = 1'b1;
        $display("TEST PASSED");
        $finish;
    end

    // A run stopped by a failing assertion still ends with a verdict
    final begin
        if (!verdict_given) begin
            $display("TEST FAILED");
        end
    end

endmodule

`default_nettype wire

// File: blk_pkg.sv
// ============================================================
// Field types of the host block interface
// Slot vectors are sized by BLK_VDNUM from blk_defines.svh
// A block count of zero requests exactly one sector
// ============================================================

`default_nettype none

`include "blk_defines.svh"

package blk_pkg;

    // Sector address as seen by the host
    typedef logic [31:0] lba_t;

    // Block count field, zero means a single sector
    typedef logic [5:0] blk_cnt_t;

    // Byte address into the shared host buffer
    typedef logic [13:0] buff_addr_t;

    // One data byte on the buffer port
    typedef logic [7:0] byte_t;

    // Image size in bytes as reported on mount
    typedef logic [63:0] img_size_t;

    // Byte index inside one sector
    typedef logic [8:0] sector_idx_t;

    // Wrapping sum of the bytes of a sector
    typedef logic [15:0] csum_t;

    // One bit per slot for rd, wr, ack, mount and enable
    typedef logic [`BLK_VDNUM-1:0] slot_vec_t;

endpackage

`default_nettype wire

// File: fdd_sector_reader.sv
// ============================================================
// Reads one sector from the host and sums its bytes
// A start while busy is ignored, err pulses when unmounted or
// when the sector does not lie fully inside the image
// Only buffer writes below one sector enter the checksum
// csum is valid with done and holds until the next request
// ============================================================

`timescale 1ns/10ps
`default_nettype none

`include "blk_defines.svh"

module fdd_sector_reader (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         start,
    input  wire blk_pkg::lba_t          start_lba,
    input  wire                         ack,
    input  wire                         buff_wr,
    input  wire blk_pkg::buff_addr_t    buff_addr,
    input  wire blk_pkg::byte_t         buff_dout,
    input  wire                         mounted,
    input  wire blk_pkg::img_size_t     img_size,
    output blk_pkg::lba_t               lba,
    output logic                        rd,
    output logic                        done,
    output logic                        err,
    output blk_pkg::csum_t              csum
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_XFER
    } state_t;

    state_t             state;
    blk_pkg::img_size_t sector_end;
    logic               req_ok;
    logic               byte_ok;

    // Byte offset just past the requested sector
    assign sector_end = (blk_pkg::img_size_t'(start_lba) + 64'd1) * `BLK_SECTOR_BYTES;

    // The whole sector has to fit inside the mounted image
    assign req_ok = mounted && (sector_end <= img_size);

    // A byte counts when the host writes it during our transfer
    assign byte_ok = ack && buff_wr &&
                     (buff_addr < blk_pkg::buff_addr_t'(`BLK_SECTOR_BYTES));

    // Request FSM, rd is held until the host acknowledges
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            rd    <= 1'b0;
            done  <= 1'b0;
            err   <= 1'b0;
        end else begin
            done <= 1'b0;
            err  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        if (req_ok) begin
                            rd    <= 1'b1;
                            state <= ST_REQ;
                        end else begin
                            err <= 1'b1;
                        end
                    end
                end
                ST_REQ: begin
                    // The host owns the transfer from its first ack cycle
                    if (ack) begin
                        rd    <= 1'b0;
                        state <= ST_XFER;
                    end
                end
                ST_XFER: begin
                    // Falling ack ends the sector
                    if (!ack) begin
                        done  <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Address and checksum are captured on an accepted start
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start && req_ok) begin
            lba  <= start_lba;
            csum <= '0;
        end else if (state != ST_IDLE && byte_ok) begin
            // The sum wraps at 16 bits
            csum <= csum + blk_pkg::csum_t'(buff_dout);
        end
    end

endmodule

`default_nettype wire

// File: nvram_sector_store.sv
// ============================================================
// One 512-byte sector of NVRAM with write-back to the host
// core_q returns the old byte when read and write coincide
// A save needs a mounted, writable image, else err pulses
// Host bytes come one cycle after each buffer address
// ============================================================

`timescale 1ns/10ps
`default_nettype none

`include "blk_defines.svh"

module nvram_sector_store (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         core_we,
    input  wire blk_pkg::sector_idx_t   core_addr,
    input  wire blk_pkg::byte_t         core_data,
    input  wire                         save,
    input  wire blk_pkg::lba_t          save_lba,
    input  wire                         ack,
    input  wire blk_pkg::buff_addr_t    buff_addr,
    input  wire                         mounted,
    input  wire                         readonly,
    output blk_pkg::byte_t              core_q,
    output blk_pkg::lba_t               lba,
    output logic                        wr,
    output blk_pkg::byte_t              buff_din,
    output logic                        saved,
    output logic                        err
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_XFER
    } state_t;

    state_t         state;
    blk_pkg::byte_t mem [`BLK_SECTOR_BYTES];
    logic           host_hit;

    // Core port with one cycle of read latency
    always_ff @(posedge clk) begin
        if (core_we) begin
            mem[core_addr] <= core_data;
        end
        core_q <= mem[core_addr];
    end

    // Addresses past the sector read back as zero
    assign host_hit = ack && (buff_addr < blk_pkg::buff_addr_t'(`BLK_SECTOR_BYTES));

    // Host read port, registered like a block RAM output
    always_ff @(posedge clk) begin
        buff_din <= host_hit ? mem[blk_pkg::sector_idx_t'(buff_addr)] : '0;
    end

    // Write-back FSM, wr is held until the host acknowledges
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            wr    <= 1'b0;
            saved <= 1'b0;
            err   <= 1'b0;
        end else begin
            saved <= 1'b0;
            err   <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (save) begin
                        if (mounted && !readonly) begin
                            wr    <= 1'b1;
                            state <= ST_REQ;
                        end else begin
                            err <= 1'b1;
                        end
                    end
                end
                ST_REQ: begin
                    if (ack) begin
                        wr    <= 1'b0;
                        state <= ST_XFER;
                    end
                end
                ST_XFER: begin
                    // The host has taken the sector once ack drops
                    if (!ack) begin
                        saved <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Target sector is fixed for the whole write-back
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && save) begin
            lba <= save_lba;
        end
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
blk_pkg.sv
blk_dev_mux.sv
fdd_sector_reader.sv
nvram_sector_store.sv
blk_dev_subsys.sv
blk_dev_subsys_chk.sv
blk_dev_subsys_tb.sv
